// File: sources.f
common/ps2_pkg.sv
common/ps2_rx_if.sv
rtl/ps2_line_sync.sv
ps2_frame_rx/ps2_frame_rx.sv
rtl/ps2_stall_timer.sv
rtl/key_event_unit.sv
rtl/ps2_keyboard_top.sv
verif/ps2_keyboard_asserts.sv
verif/tb_ps2_keyboard.sv

// File: Bender.yml
package:
  name: ps2_keyboard

sources:
  - common/ps2_pkg.sv
  - common/ps2_rx_if.sv
  - rtl/ps2_line_sync.sv
  - ps2_frame_rx/ps2_frame_rx.sv
  - rtl/ps2_stall_timer.sv
  - rtl/key_event_unit.sv
  - rtl/ps2_keyboard_top.sv
  - target: test
    files:
      - verif/ps2_keyboard_asserts.sv
      - verif/tb_ps2_keyboard.sv

// File: verif/tb_ps2_keyboard.sv
// PS/2 keyboard receiver testbench: keyboard device model, reference model and event checker
module tb_ps2_keyboard;
    import ps2_pkg::*;

    localparam int HALF_CLKS  = 20;              // PS/2 half period in system clocks
    localparam int BIT_CLKS   = 2 * HALF_CLKS;
    localparam int N_RAND     = 8;               // Plain random make codes
    localparam int NUM_FRAMES = N_RAND + 28;
    localparam int NUM_STALLS = 1;
    // 11 bits plus one bit time of idle gap per frame, then the stall waits and reset
    localparam int WATCHDOG_TIME =
        (NUM_FRAMES * 12 * BIT_CLKS + NUM_STALLS * (STALL_CYCLES + BIT_CLKS) + 100) * 8;

    typedef struct packed {
        err_cnt_t err;   // Error count seen with the event
        logic     ext;
        logic     rel;
        scan_t    code;
    } key_ev_t;

    logic clk, rst_n, ps2_clk, ps2_data;
    scan_t key_code;
    logic key_extended, key_released, key_strobe;
    err_cnt_t error_count;

    key_ev_t  exp_q[$];                 // Events still to be seen
    key_ev_t  got_ev;
    logic     m_ext, m_brk;             // Model prefix flags
    err_cnt_t m_err;                    // Model error count
    integer   seed;
    int       mismatches, other_errors;

    ps2_keyboard_top dut0 (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;               // Period 8

    // ----------------------------------------------------------------------
    // Reference model and stimulus helpers
    // ----------------------------------------------------------------------
    function automatic void predict_frame(input scan_t code, input bit bad);
        key_ev_t ev;
        if (bad) begin
            if (m_err != 4'd15) m_err = m_err + 4'd1;  // Saturates at 15
            m_ext = 1'b0;                              // Prefixes are lost
            m_brk = 1'b0;
        end else if (code == BYTE_EXT) begin
            m_ext = 1'b1;
        end else if (code == BYTE_BREAK) begin
            m_brk = 1'b1;
        end else begin
            ev = '{err: m_err, ext: m_ext, rel: m_brk, code: code};
            exp_q.push_back(ev);
            m_ext = 1'b0;
            m_brk = 1'b0;
        end
    endfunction

    function automatic scan_t next_make_code();
        scan_t c;
        do begin
            c = scan_t'($random(seed));
        end while (c == BYTE_EXT || c == BYTE_BREAK);   // Prefixes excluded
        return c;
    endfunction

    task automatic step_clks(input int n);
        repeat (n) @(posedge clk);
        #1;                                 // Drive just after the edge
    endtask

    // Keyboard model, lines driven low or released high
    task automatic drive_frame(input scan_t code, input bit bad_par, input bit bad_stop,
                               input int data_bits);
        logic [10:0] bits;
        int          n_bits;
        bits   = {~bad_stop, (~^code) ^ bad_par, code, 1'b0};  // Stop, odd parity, data, start
        n_bits = (data_bits >= 8) ? 11 : data_bits + 1;       // Clock dies early on a stall
        for (int k = 0; k < n_bits; k++) begin
            ps2_data = bits[k];             // Data moves while clock is high
            step_clks(HALF_CLKS);
            ps2_clk = 1'b0;
            step_clks(HALF_CLKS);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        step_clks(BIT_CLKS);                // Idle gap between frames
    endtask

    task automatic send_byte(input scan_t code, input bit bad_par, input bit bad_stop,
                             input int data_bits);
        predict_frame(code, bad_par || bad_stop || (data_bits < 8));
        drive_frame(code, bad_par, bad_stop, data_bits);
        if (data_bits < 8) step_clks(STALL_CYCLES + BIT_CLKS);   // Let the timer fire
    endtask

    task automatic compare_value(input string name, input logic [7:0] exp_v,
                                 input logic [7:0] act_v);
        assert (act_v === exp_v) else begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, exp_v, act_v);
            mismatches++;
        end
    endtask

    // ----------------------------------------------------------------------
    // Checker, samples on the falling clock edge
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && key_strobe) begin
            assert (exp_q.size() > 0) else begin
                $display("Unexpected key_strobe at time %0t, no key event was due", $time);
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                got_ev = exp_q.pop_front();
                compare_value("key_code", got_ev.code, key_code);
                compare_value("key_extended", got_ev.ext, key_extended);
                compare_value("key_released", got_ev.rel, key_released);
                compare_value("error_count", got_ev.err, error_count);
            end
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: run still going after %0d time units", WATCHDOG_TIME);
        $display("RESULT: FAIL");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        int total;
        seed = 32'h38f9;
        {rst_n, ps2_clk, ps2_data} = 3'b011;    // Lines idle high
        {m_ext, m_brk, m_err} = '0;
        mismatches   = 0;
        other_errors = 0;
        step_clks(8);
        rst_n = 1'b1;
        step_clks(4);
        for (int i = 0; i < N_RAND; i++) send_byte(next_make_code(), 0, 0, 8);
        send_byte(BYTE_BREAK, 0, 0, 8);          // Release
        send_byte(next_make_code(), 0, 0, 8);
        send_byte(BYTE_EXT, 0, 0, 8);            // Extended release, then plain key
        send_byte(BYTE_BREAK, 0, 0, 8);
        send_byte(next_make_code(), 0, 0, 8);
        send_byte(next_make_code(), 0, 0, 8);
        send_byte(BYTE_EXT, 0, 0, 8);            // Parity error drops the E0
        send_byte(next_make_code(), 1, 0, 8);
        send_byte(next_make_code(), 0, 0, 8);
        send_byte(next_make_code(), 0, 1, 8);    // Low stop bit
        send_byte(next_make_code(), 0, 0, 8);
        send_byte(next_make_code(), 0, 0, 4);    // Clock stops after four data bits
        send_byte(next_make_code(), 0, 0, 8);
        repeat (14) send_byte(next_make_code(), 1, 0, 8);   // Drive count past 15
        send_byte(next_make_code(), 0, 0, 8);
        step_clks(20);
        assert (exp_q.size() == 0) else begin
            $display("%0d expected key events never appeared", exp_q.size());
            other_errors++;
        end
        compare_value("error_count", m_err, error_count);
        total = mismatches + other_errors + dut0.u_asserts.fail_count;
        $display("Checks finished: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatches, other_errors, dut0.u_asserts.fail_count);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/ps2_keyboard_asserts.sv
// PS/2 keyboard receiver assertions: key strobe, error counter and key code rules at the top
module ps2_keyboard_asserts (
    input logic              clk,
    input logic              rst_n,
    input logic              key_strobe,
    input ps2_pkg::scan_t    key_code,
    input ps2_pkg::err_cnt_t error_count
);

    int fail_count = 0;  // Read by the testbench at the end

    // One event per clean key byte, never back to back
    strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        key_strobe |=> !key_strobe)
    else begin
        $error("key_strobe high on two consecutive cycles");
        fail_count++;
    end

    // Counter only moves up, then sticks at its maximum
    err_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        error_count >= $past(error_count))
    else begin
        $error("error_count decreased outside reset");
        fail_count++;
    end

    code_held: assert property (@(posedge clk) disable iff (!rst_n)
        !key_strobe |-> $stable(key_code))
    else begin
        $error("key_code changed without key_strobe");
        fail_count++;
    end

endmodule

bind ps2_keyboard_top ps2_keyboard_asserts u_asserts (
    .clk         (clk),
    .rst_n       (rst_n),
    .key_strobe  (key_strobe),
    .key_code    (key_code),
    .error_count (error_count)
);

// File: rtl/ps2_keyboard_top.sv
// PS/2 keyboard receiver top: line sync, frame receiver, stall timer and key event unit
module ps2_keyboard_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ps2_clk,       // From keyboard connector
    input  logic              ps2_data,      // From keyboard connector
    output ps2_pkg::scan_t    key_code,
    output logic              key_extended,
    output logic              key_released,
    output logic              key_strobe,
    output ps2_pkg::err_cnt_t error_count
);

    logic fall;     // Synced PS/2 clock falling edge
    logic bit_val;  // Synced PS/2 data
    logic busy;     // Frame in progress
    logic stall;    // Frame aborted

    ps2_rx_if rx_bus ();  // Byte channel, receiver to event unit

    ps2_line_sync u_line_sync (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .fall     (fall),
        .bit_val  (bit_val)
    );

    ps2_frame_rx u_frame_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .fall    (fall),
        .bit_val (bit_val),
        .stall   (stall),
        .rx      (rx_bus.rx),
        .busy    (busy)
    );

    ps2_stall_timer u_stall_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .fall  (fall),
        .busy  (busy),
        .stall (stall)
    );

    key_event_unit u_key_event (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx           (rx_bus.sink),
        .stall        (stall),
        .key_code     (key_code),
        .key_extended (key_extended),
        .key_released (key_released),
        .key_strobe   (key_strobe),
        .error_count  (error_count)
    );

endmodule

// File: rtl/key_event_unit.sv
// Key event unit: folds E0/F0 prefixes into key events and counts bad or stalled frames
module key_event_unit (
    input  logic              clk,
    input  logic              rst_n,
    ps2_rx_if.sink            rx,            // Bytes from frame receiver
    input  logic              stall,         // Aborted frame pulse
    output ps2_pkg::scan_t    key_code,      // Last key scan code
    output logic              key_extended,  // Last key had E0 prefix
    output logic              key_released,  // Last key had F0 prefix
    output logic              key_strobe,    // One-cycle new event pulse
    output ps2_pkg::err_cnt_t error_count    // Saturating error count
);
    import ps2_pkg::*;

    logic ext_pend;   // E0 seen, waiting for key byte
    logic brk_pend;   // F0 seen, waiting for key byte
    logic bad_frame;  // Frame lost for any reason
    logic good_byte;  // Clean byte this cycle

    assign bad_frame = stall || (rx.done && (rx.parity_err || rx.stop_err));
    assign good_byte = rx.done && !rx.parity_err && !rx.stop_err;

    // ----------------------------------------------------------------------
    // Prefix folding and event output
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_pend     <= 1'b0;
            brk_pend     <= 1'b0;
            key_code     <= '0;
            key_extended <= 1'b0;
            key_released <= 1'b0;
            key_strobe   <= 1'b0;
        end else begin
            key_strobe <= 1'b0;
            if (bad_frame) begin
                ext_pend <= 1'b0;               // Prefix context lost
                brk_pend <= 1'b0;
            end else if (good_byte) begin
                if (rx.data == BYTE_EXT) begin
                    ext_pend <= 1'b1;
                end else if (rx.data == BYTE_BREAK) begin
                    brk_pend <= 1'b1;
                end else begin
                    // Plain code byte, emit event with gathered flags
                    key_code     <= rx.data;
                    key_extended <= ext_pend;
                    key_released <= brk_pend;
                    key_strobe   <= 1'b1;
                    ext_pend     <= 1'b0;
                    brk_pend     <= 1'b0;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Error counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_count <= '0;
        end else if (bad_frame && (error_count != ERR_MAX)) begin
            error_count <= error_count + err_cnt_t'(1);  // Stick at max
        end
    end

endmodule

// File: rtl/ps2_stall_timer.sv
// PS/2 stall timer: times the gap between PS/2 clock edges in a frame and flags a stalled frame
module ps2_stall_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic fall,   // PS/2 clock falling edge pulse
    input  logic busy,   // Frame in progress
    output logic stall   // One-cycle abort pulse
);
    import ps2_pkg::*;

    stall_cnt_t cnt;     // Clocks since last falling edge
    logic       armed;   // One pulse per frame at most
    logic       hit;     // Limit reached this cycle

    assign hit = busy && armed && !fall && (cnt == STALL_CYCLES);

    // ----------------------------------------------------------------------
    // Gap counter, saturates at the limit
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (fall || !busy) begin
            cnt <= '0;                      // Edge seen, or no frame open
        end else if (cnt != STALL_CYCLES) begin
            cnt <= cnt + stall_cnt_t'(1);
        end
    end

    // ----------------------------------------------------------------------
    // Pulse and re-arm
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed <= 1'b1;
            stall <= 1'b0;
        end else begin
            stall <= hit;                   // Appears the cycle after the limit
            if (hit) begin
                armed <= 1'b0;              // Hold off until busy falls
            end else if (!busy) begin
                armed <= 1'b1;
            end
        end
    end

endmodule

// File: ps2_frame_rx/ps2_frame_rx.sv
// PS/2 frame receiver: FSM that assembles 11-bit frames and checks odd parity and the stop bit
module ps2_frame_rx (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fall,     // Sample strobe from line sync
    input  logic    bit_val,  // Synchronized data level
    input  logic    stall,    // Abort request from stall timer
    ps2_rx_if.rx    rx,       // Byte and status out
    output logic    busy      // Frame in progress
);
    import ps2_pkg::*;

    rx_state_e  state;
    logic [2:0] bit_cnt;   // Data bits taken so far, minus one
    scan_t      shift_q;   // Data shift register, LSB arrives first
    logic       par_bit;   // Sampled parity bit

    // ----------------------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= rx_idle;
            bit_cnt <= 3'd0;
            rx.done <= 1'b0;
        end else begin
            rx.done <= 1'b0;                  // Default, pulse only
            if (stall) begin
                state <= rx_idle;             // Clock died mid-frame, drop it
            end else if (fall) begin
                unique case (state)
                    rx_idle: begin
                        if (!bit_val) begin   // Start bit is low
                            state   <= rx_data;
                            bit_cnt <= 3'd0;
                        end
                    end
                    rx_data: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= rx_parity;  // Eighth bit taken
                        end
                    end
                    rx_parity: state <= rx_stop;
                    rx_stop: begin
                        state   <= rx_idle;
                        rx.done <= 1'b1;      // Frame complete
                    end
                    default: state <= rx_idle;
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // Datapath: byte, parity bit and status flags
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fall) begin
            if (state == rx_data) begin
                shift_q <= {bit_val, shift_q[7:1]};  // LSB first
            end
            if (state == rx_parity) begin
                par_bit <= bit_val;
            end
            if (state == rx_stop) begin
                // Odd parity over data plus parity bit, so even weight is bad
                rx.parity_err <= ~(^{par_bit, shift_q});
                rx.stop_err   <= ~bit_val;        // Stop bit must be high
            end
        end
    end

    assign rx.data = shift_q;            // Held stable until next frame shifts
    assign busy    = (state != rx_idle); // Start bit through stop bit

endmodule

// File: rtl/ps2_line_sync.sv
// PS/2 line synchronizer: brings clock and data into clk domain, flags PS/2 clock falling edges
module ps2_line_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic ps2_clk,   // Open-collector line from the keyboard
    input  logic ps2_data,  // Open-collector line from the keyboard
    output logic fall,      // One-cycle pulse per PS/2 clock falling edge
    output logic bit_val    // Data level, aligned with fall
);

    logic clk_s1, clk_s2;    // Two-stage sync of PS/2 clock
    logic data_s1, data_s2;  // Two-stage sync of PS/2 data
    logic clk_q;             // Previous synchronized clock level

    // Lines idle high, so reset to high to avoid a false edge after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_s1  <= 1'b1;
            clk_s2  <= 1'b1;
            clk_q   <= 1'b1;
            data_s1 <= 1'b1;
            data_s2 <= 1'b1;
            fall    <= 1'b0;
            bit_val <= 1'b1;
        end else begin
            clk_s1  <= ps2_clk;
            clk_s2  <= clk_s1;
            clk_q   <= clk_s2;
            data_s1 <= ps2_data;
            data_s2 <= data_s1;
            fall    <= clk_q & ~clk_s2;  // High to low seen on synced clock
            bit_val <= data_s2;          // Same stage as fall
        end
    end

endmodule

// File: common/ps2_rx_if.sv
// Received byte channel: one scan code byte plus frame status, frame receiver to key event unit
interface ps2_rx_if;
    import ps2_pkg::*;

    scan_t data;        // Assembled byte, valid with done
    logic  done;        // One-cycle pulse, a frame has ended
    logic  parity_err;  // Nine sampled bits had even weight
    logic  stop_err;    // Stop bit sampled low

    // Frame receiver side
    modport rx (
        output data, done, parity_err, stop_err
    );

    // Consumer side, no back-pressure
    modport sink (
        input data, done, parity_err, stop_err
    );

endinterface

// File: common/ps2_pkg.sv
// PS/2 keyboard receiver package: width types, receiver FSM states, protocol constants
package ps2_pkg;

    // ----------------------------------------------------------------------
    // Width types
    // ----------------------------------------------------------------------
    typedef logic [7:0] scan_t;       // One scan code byte from the keyboard
    typedef logic [3:0] err_cnt_t;    // Saturating count of bad frames
    typedef logic [7:0] stall_cnt_t;  // System clocks since last PS/2 edge

    // ----------------------------------------------------------------------
    // Frame receiver states
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        rx_idle,    // Waiting for a low start bit
        rx_data,    // Shifting in eight data bits, LSB first
        rx_parity,  // Sampling the odd parity bit
        rx_stop     // Sampling the stop bit
    } rx_state_e;

    // ----------------------------------------------------------------------
    // Protocol constants
    // ----------------------------------------------------------------------
    // Prefix bytes of set 2 scan codes
    localparam scan_t BYTE_EXT   = 8'hE0;  // Extended key follows
    localparam scan_t BYTE_BREAK = 8'hF0;  // Key release follows

    // A keyboard clocks at 10..16.7 kHz, so a silent line this long
    // in the middle of a frame means the frame is lost
    localparam stall_cnt_t STALL_CYCLES = 8'd200;

    localparam err_cnt_t ERR_MAX = 4'd15;  // Error counter saturates here

endpackage
